//--- source/timer_pkg.sv
// Shared constants for the AHB3-Lite timer
// Bus widths, channel count, register offsets, AHB codes
// and the 64-bit time word shared by time and timecmp

package timer_pkg;

  //////////////////////////////////////////////////
  // Sizes

  // Number of compare channels
  localparam int TIMERS = 3;

  localparam int HADDR_SIZE = 32;
  localparam int HDATA_SIZE = 32;
  localparam int BE_SIZE    = HDATA_SIZE / 8;

  //////////////////////////////////////////////////
  // Register map, byte offsets

  localparam logic [HADDR_SIZE-1:0] ADDR_PRESCALE = 'h00;
  localparam logic [HADDR_SIZE-1:0] ADDR_RESERVED = 'h04;
  localparam logic [HADDR_SIZE-1:0] ADDR_IPENDING = 'h08;
  localparam logic [HADDR_SIZE-1:0] ADDR_IENABLE  = 'h0C;
  localparam logic [HADDR_SIZE-1:0] ADDR_TIME     = 'h10;
  localparam logic [HADDR_SIZE-1:0] ADDR_TIME_MSB = 'h14;
  // Channel n sits at this base + 8*n, high half 4 above
  localparam logic [HADDR_SIZE-1:0] ADDR_TIMECMP  = 'h18;

  //////////////////////////////////////////////////
  // AHB encodings

  localparam logic [1:0] HTRANS_IDLE = 2'b00;
  localparam logic [1:0] HTRANS_BUSY = 2'b01;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY = 1'b0;

  // Time word, seen whole for count and compare,
  // or as two bus-wide halves for access
  typedef union packed {
    logic [63:0] full;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } timer_word_u;

endpackage

//--- source/timer_bus_port.sv
// AHB3-Lite slave port of the timer
// Write address phase capture, byte enable decode, fixed response

`timescale 1ns/1ps

module timer_bus_port (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             HSEL,
  input  logic                             HWRITE,
  input  logic [1:0]                       HTRANS,
  input  logic [2:0]                       HSIZE,
  input  logic [timer_pkg::HADDR_SIZE-1:0] HADDR,
  input  logic                             HREADY,
  output logic                             wr_en,
  output logic [timer_pkg::BE_SIZE-1:0]    wr_be,
  output logic [timer_pkg::HADDR_SIZE-1:0] wr_addr,
  output logic                             HREADYOUT,
  output logic                             HRESP
);

  import timer_pkg::*;

  logic               wr_req;
  logic [BE_SIZE-1:0] be_next;

  // Zero wait states, never an error
  assign HREADYOUT = 1'b1;
  assign HRESP     = HRESP_OKAY;

  // Real write transfer to this slave
  assign wr_req = HSEL & HWRITE & (HTRANS != HTRANS_IDLE) & (HTRANS != HTRANS_BUSY);

  // Active lanes from size and low address bits
  always_comb
  begin
    case (HSIZE)
      HSIZE_BYTE:  be_next = 4'b0001 << HADDR[1:0];
      HSIZE_HWORD: be_next = 4'b0011 << {HADDR[1], 1'b0};
      HSIZE_WORD:  be_next = 4'b1111;
      default:     be_next = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // Address phase capture, frozen while stalled

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wr_en <= 1'b0;
    else if (HREADY)
      wr_en <= wr_req;
  end

  always_ff @(posedge HCLK)
  begin
    if (HREADY)
    begin
      wr_be   <= be_next;
      wr_addr <= HADDR;
    end
  end

  // Data phase write must carry at least one lane
  a_wr_be_nonzero: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wr_en |-> (wr_be != '0));

endmodule

//--- source/timer_prescaler.sv
// Global prescaler
// Reloadable down-counter giving the time count strobe

`timescale 1ns/1ps

module timer_prescaler (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [timer_pkg::HDATA_SIZE-1:0] prescale_value,
  input  logic                             prescale_load,
  input  logic                             counting,
  output logic                             count_en
);

  import timer_pkg::*;

  logic [HDATA_SIZE-1:0] cnt;
  logic                  cnt_zero;

  assign cnt_zero = (cnt == '0);

  // Reload on new prescale or at terminal count
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      cnt <= '0;
    else if (prescale_load || cnt_zero)
      cnt <= prescale_value;
    else
      cnt <= cnt - 1'b1;
  end

  // One strobe per prescale_value+1 cycles
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count_en <= 1'b0;
    else
      count_en <= counting & cnt_zero;
  end

  // Counting never drops once started, so no strobe without it
  a_no_strobe_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !counting |-> !count_en);

endmodule

//--- source/timer_regs.sv
// Timer register file
// Write decode and byte merge, time counter, compare match,
// registered read mux

`timescale 1ns/1ps

module timer_regs (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             wr_en,
  input  logic [timer_pkg::BE_SIZE-1:0]    wr_be,
  input  logic [timer_pkg::HADDR_SIZE-1:0] wr_addr,
  input  logic [timer_pkg::HDATA_SIZE-1:0] HWDATA,
  input  logic [timer_pkg::HADDR_SIZE-1:0] HADDR,
  input  logic                             HREADY,
  input  logic                             count_en,
  input  logic [timer_pkg::TIMERS-1:0]     pending,
  output logic [timer_pkg::HDATA_SIZE-1:0] HRDATA,
  output logic [timer_pkg::HDATA_SIZE-1:0] prescale_value,
  output logic                             prescale_load,
  output logic                             counting,
  output logic [timer_pkg::TIMERS-1:0]     ienable,
  output logic [timer_pkg::TIMERS-1:0]     match,
  output logic [timer_pkg::TIMERS-1:0]     cmp_clear
);

  import timer_pkg::*;

  // Keep old bytes where the lane is not enabled
  function automatic logic [HDATA_SIZE-1:0] merge(input logic [HDATA_SIZE-1:0] old_val,
                                                 input logic [HDATA_SIZE-1:0] new_val,
                                                 input logic [BE_SIZE-1:0]    be);
    for (int b = 0; b < BE_SIZE; b++)
      merge[b*8 +: 8] = be[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
  endfunction

  logic [HDATA_SIZE-1:0] prescale_reg;
  timer_word_u           time_reg;
  timer_word_u           timecmp_reg [TIMERS];

  logic                  wr_go;
  logic [HADDR_SIZE-1:0] wr_word;
  logic [HADDR_SIZE-1:0] rd_word;
  logic                  prescale_sel;
  logic [TIMERS-1:0]     cmp_lo_sel;
  logic [TIMERS-1:0]     cmp_hi_sel;
  logic [HDATA_SIZE-1:0] ienable_merged;
  logic [HDATA_SIZE-1:0] rd_next;

  //////////////////////////////////////////////////
  // Write decode

  // Data phase completes with HREADY
  assign wr_go   = wr_en & HREADY;
  assign wr_word = {wr_addr[HADDR_SIZE-1:2], 2'b00};

  assign prescale_sel = wr_go & (wr_word == ADDR_PRESCALE);

  // Channels beyond TIMERS decode to nothing
  always_comb
  begin
    for (int n = 0; n < TIMERS; n++)
    begin
      cmp_lo_sel[n] = wr_go & (wr_word == ADDR_TIMECMP + HADDR_SIZE'(8 * n));
      cmp_hi_sel[n] = wr_go & (wr_word == ADDR_TIMECMP + HADDR_SIZE'(8 * n + 4));
    end
  end

  // Either half of timecmp[n] clears pending[n]
  assign cmp_clear = cmp_lo_sel | cmp_hi_sel;

  // Only the low TIMERS enable bits exist
  assign ienable_merged = merge({{(HDATA_SIZE-TIMERS){1'b0}}, ienable}, HWDATA, wr_be);

  assign prescale_value = prescale_reg;

  //////////////////////////////////////////////////
  // Registers

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prescale_reg  <= '0;
      prescale_load <= 1'b0;
      counting      <= 1'b0;
      ienable       <= '0;
      time_reg      <= '0;
      for (int n = 0; n < TIMERS; n++)
        timecmp_reg[n] <= '0;
    end
    else
    begin
      prescale_load <= prescale_sel;
      if (prescale_sel)
      begin
        prescale_reg <= merge(prescale_reg, HWDATA, wr_be);
        // First prescale write starts the counter
        counting     <= 1'b1;
      end
      if (wr_go && wr_word == ADDR_IENABLE)
        ienable <= ienable_merged[TIMERS-1:0];
      // Bus write beats the increment
      if (wr_go && wr_word == ADDR_TIME)
        time_reg.half.lo <= merge(time_reg.half.lo, HWDATA, wr_be);
      else if (wr_go && wr_word == ADDR_TIME_MSB)
        time_reg.half.hi <= merge(time_reg.half.hi, HWDATA, wr_be);
      else if (count_en)
        time_reg.full <= time_reg.full + 64'd1;
      for (int n = 0; n < TIMERS; n++)
      begin
        if (cmp_lo_sel[n])
          timecmp_reg[n].half.lo <= merge(timecmp_reg[n].half.lo, HWDATA, wr_be);
        if (cmp_hi_sel[n])
          timecmp_reg[n].half.hi <= merge(timecmp_reg[n].half.hi, HWDATA, wr_be);
      end
    end
  end

  // Compare, only once the counter runs
  always_comb
  begin
    for (int n = 0; n < TIMERS; n++)
      match[n] = counting & (time_reg.full == timecmp_reg[n].full);
  end

  //////////////////////////////////////////////////
  // Read path, decoded in the address phase

  assign rd_word = {HADDR[HADDR_SIZE-1:2], 2'b00};

  always_comb
  begin
    rd_next = '0;
    case (rd_word)
      ADDR_PRESCALE: rd_next = prescale_reg;
      ADDR_RESERVED: rd_next = '0;
      ADDR_IPENDING: rd_next = {{(HDATA_SIZE-TIMERS){1'b0}}, pending};
      ADDR_IENABLE:  rd_next = {{(HDATA_SIZE-TIMERS){1'b0}}, ienable};
      ADDR_TIME:     rd_next = time_reg.half.lo;
      ADDR_TIME_MSB: rd_next = time_reg.half.hi;
      default:
        for (int n = 0; n < TIMERS; n++)
        begin
          if (rd_word == ADDR_TIMECMP + HADDR_SIZE'(8 * n))
            rd_next = timecmp_reg[n].half.lo;
          else if (rd_word == ADDR_TIMECMP + HADDR_SIZE'(8 * n + 4))
            rd_next = timecmp_reg[n].half.hi;
        end
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (HREADY)
      HRDATA <= rd_next;
  end

  // One data phase clears at most one channel
  a_clear_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(cmp_clear));

endmodule

//--- source/timer_irq.sv
// Interrupt logic of the timer
// Sticky per-channel pending bits and the combined tint output

`timescale 1ns/1ps

module timer_irq (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic [timer_pkg::TIMERS-1:0] match,
  input  logic [timer_pkg::TIMERS-1:0] cmp_clear,
  input  logic [timer_pkg::TIMERS-1:0] ienable,
  output logic [timer_pkg::TIMERS-1:0] pending,
  output logic                         tint
);

  //////////////////////////////////////////////////
  // Pending bits

  // Set on match, held until timecmp is rewritten
  // Clear wins over a match in the same cycle
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      pending <= '0;
    else
      pending <= (pending | match) & ~cmp_clear;
  end

  //////////////////////////////////////////////////
  // Interrupt output

  // Masked channels still show pending
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      tint <= 1'b0;
    else
      tint <= |(pending & ienable);
  end

endmodule

//--- source/timer_top.sv
// AHB3-Lite timer top level
// Bus port, register file, prescaler and interrupt logic

`timescale 1ns/1ps

module timer_top (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             HSEL,
  input  logic [timer_pkg::HADDR_SIZE-1:0] HADDR,
  input  logic [timer_pkg::HDATA_SIZE-1:0] HWDATA,
  input  logic                             HWRITE,
  input  logic [2:0]                       HSIZE,
  input  logic [1:0]                       HTRANS,
  input  logic                             HREADY,
  output logic [timer_pkg::HDATA_SIZE-1:0] HRDATA,
  output logic                             HREADYOUT,
  output logic                             HRESP,
  output logic                             tint
);

  import timer_pkg::*;

  // Data phase write request
  logic                  wr_en;
  logic [BE_SIZE-1:0]    wr_be;
  logic [HADDR_SIZE-1:0] wr_addr;

  // Prescaler handshake
  logic [HDATA_SIZE-1:0] prescale_value;
  logic                  prescale_load;
  logic                  counting;
  logic                  count_en;

  // Channel status
  logic [TIMERS-1:0]     ienable;
  logic [TIMERS-1:0]     match;
  logic [TIMERS-1:0]     cmp_clear;
  logic [TIMERS-1:0]     pending;

  timer_bus_port u_bus_port (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HADDR     (HADDR),
    .HREADY    (HREADY),
    .wr_en     (wr_en),
    .wr_be     (wr_be),
    .wr_addr   (wr_addr),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

  timer_regs u_regs (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .wr_en          (wr_en),
    .wr_be          (wr_be),
    .wr_addr        (wr_addr),
    .HWDATA         (HWDATA),
    .HADDR          (HADDR),
    .HREADY         (HREADY),
    .count_en       (count_en),
    .pending        (pending),
    .HRDATA         (HRDATA),
    .prescale_value (prescale_value),
    .prescale_load  (prescale_load),
    .counting       (counting),
    .ienable        (ienable),
    .match          (match),
    .cmp_clear      (cmp_clear)
  );

  timer_prescaler u_prescaler (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .prescale_value (prescale_value),
    .prescale_load  (prescale_load),
    .counting       (counting),
    .count_en       (count_en)
  );

  timer_irq u_irq (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .match     (match),
    .cmp_clear (cmp_clear),
    .ienable   (ienable),
    .pending   (pending),
    .tint      (tint)
  );

endmodule

//--- sim/tb_timer.sv
// Self-checking testbench for the AHB3-Lite timer
// Stimulus table, LCG data, AHB single-transfer tasks, value checks

`timescale 1ns/1ps

module tb_timer;

  import timer_pkg::*;

  localparam int         CLK_HALF      = 4;
  localparam int         RST_CYCLES    = 10;
  localparam int         WAIT_MAX      = 4000;
  localparam int         POLL_MAX      = 200;
  localparam int         ROWS          = 18;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  HSEL;
  logic [HADDR_SIZE-1:0] HADDR;
  logic [HDATA_SIZE-1:0] HWDATA;
  logic                  HWRITE;
  logic [2:0]            HSIZE;
  logic [1:0]            HTRANS;
  logic                  HREADY;
  logic [HDATA_SIZE-1:0] HRDATA;
  logic                  HREADYOUT;
  logic                  HRESP;
  logic                  tint;

  // Stimulus table: write address, size, data, expected readback
  logic [31:0] tab_addr [ROWS];
  logic [2:0]  tab_size [ROWS];
  logic [31:0] tab_data [ROWS];
  logic [31:0] tab_exp  [ROWS];
  int          rows_used;

  // Expected register words, indexed by address bits 5:2
  logic [31:0] model [16];

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          error_count = 0;

  timer_top u_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .tint      (tint)
  );

  always #CLK_HALF HCLK = ~HCLK;

  always @(posedge HCLK)
    cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bytes a transfer touches, from size and low address bits
  function automatic logic [31:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
    logic [31:0] m;
    case (size)
      HSIZE_BYTE:  m = 32'h0000_00FF << {addr[1:0], 3'b000};
      HSIZE_HWORD: m = addr[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
      default:     m = 32'hFFFF_FFFF;
    endcase
    return m;
  endfunction

  // Bits of a register word that a bus write can change
  function automatic logic [31:0] stored_bits(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00};
    if (w == ADDR_PRESCALE)
      return 32'hFFFF_FFFF;
    else if (w == ADDR_IENABLE)
      return (32'h1 << TIMERS) - 32'h1;
    else if (w >= ADDR_TIMECMP && w < ADDR_TIMECMP + 32'(8 * TIMERS))
      return 32'hFFFF_FFFF;
    else
      return 32'h0;
  endfunction

  function automatic logic [31:0] cmp_addr(input int n, input int hi);
    return ADDR_TIMECMP + 32'(8 * n + 4 * hi);
  endfunction

  // Append one row, expected word follows the lane merge
  function automatic void add_row(input logic [31:0] addr, input logic [2:0] size,
                                  input logic [31:0] data);
    logic [31:0] keep;
    keep = lane_mask(addr, size) & stored_bits(addr);
    model[addr[5:2]] = (model[addr[5:2]] & ~keep) | (data & keep);
    tab_addr[rows_used] = addr;
    tab_size[rows_used] = size;
    tab_data[rows_used] = data;
    tab_exp[rows_used]  = model[addr[5:2]];
    rows_used++;
  endfunction

  function automatic void build_table();
    for (int i = 0; i < 16; i++)
      model[i] = 32'h0;
    rows_used = 0;
    add_row(ADDR_PRESCALE, HSIZE_WORD, lcg_next());
    add_row(ADDR_RESERVED, HSIZE_WORD, lcg_next());
    add_row(ADDR_IPENDING, HSIZE_WORD, lcg_next());
    add_row(ADDR_IENABLE, HSIZE_WORD, lcg_next());
    for (int n = 0; n < TIMERS; n++)
    begin
      add_row(cmp_addr(n, 0), HSIZE_WORD, lcg_next());
      add_row(cmp_addr(n, 1), HSIZE_WORD, lcg_next());
    end
    // Channel index TIMERS is out of range
    add_row(cmp_addr(TIMERS, 0), HSIZE_WORD, lcg_next());
    add_row(cmp_addr(TIMERS, 1), HSIZE_WORD, lcg_next());
    // Partial writes into known words
    add_row(cmp_addr(2, 0) + 32'd1, HSIZE_BYTE, lcg_next());
    add_row(cmp_addr(2, 0) + 32'd2, HSIZE_HWORD, lcg_next());
    add_row(cmp_addr(2, 0), HSIZE_BYTE, lcg_next());
    add_row(cmp_addr(0, 1) + 32'd2, HSIZE_HWORD, lcg_next());
    add_row(ADDR_IENABLE + 32'd3, HSIZE_BYTE, lcg_next());
    add_row(ADDR_IENABLE, HSIZE_BYTE, lcg_next());
  endfunction

  //////////////////////////////////////////////////
  // Checks and failure exits

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped on a timeout");
  endtask

  //////////////////////////////////////////////////
  // AHB transfers

  // Advance to the edge that ends the current phase
  task automatic next_phase();
    int n;
    n = 0;
    @(negedge HCLK);
    while (HREADYOUT !== 1'b1)
    begin
      n++;
      if (n > WAIT_MAX)
        stop_on_timeout("HREADYOUT never went high");
      @(negedge HCLK);
    end
    @(posedge HCLK);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HADDR  <= addr;
    HWRITE <= 1'b1;
    HSIZE  <= size;
    HTRANS <= HTRANS_NONSEQ;
    next_phase();
    // Data phase, bus idle behind it
    HSEL   <= 1'b0;
    HWRITE <= 1'b0;
    HTRANS <= HTRANS_IDLE;
    HWDATA <= data;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HADDR  <= {addr[31:2], 2'b00};
    HWRITE <= 1'b0;
    HSIZE  <= HSIZE_WORD;
    HTRANS <= HTRANS_NONSEQ;
    next_phase();
    HSEL   <= 1'b0;
    HTRANS <= HTRANS_IDLE;
    // HRDATA holds through the data phase
    @(negedge HCLK);
    data = HRDATA;
    check_value("HREADYOUT", 32'(HREADYOUT), 32'h1);
    check_value("HRESP", 32'(HRESP), 32'(HRESP_OKAY));
  endtask

  task automatic wait_tint(input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge HCLK);
    while (tint !== level)
    begin
      n++;
      if (n > limit)
        stop_on_timeout(what);
      @(negedge HCLK);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    logic [31:0] rd;
    logic [31:0] t_lo;
    logic [31:0] t_hi;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [63:0] target;
    int          c0;
    int          c1;
    int          rate;
    int          delta;
    int          polls;
    int          prescale_p;

    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = '0;
    HWDATA    = '0;
    HWRITE    = 1'b0;
    HSIZE     = HSIZE_WORD;
    HTRANS    = HTRANS_IDLE;
    HREADY    = 1'b1;
    lcg_state = 32'h99679aac;
    repeat (RST_CYCLES) @(posedge HCLK);
    HRESETn <= 1'b1;

    // Time holds still until prescale is first written
    t_lo = lcg_next();
    t_hi = 32'h0000_0100;
    bus_write(ADDR_TIME, HSIZE_WORD, t_lo);
    bus_write(ADDR_TIME_MSB, HSIZE_WORD, t_hi);
    repeat (50) @(posedge HCLK);
    bus_read(ADDR_TIME, rd);
    check_value("time_lo", rd, t_lo);
    bus_read(ADDR_TIME_MSB, rd);
    check_value("time_hi", rd, t_hi);

    // Table of writes and readbacks
    build_table();
    for (int r = 0; r < rows_used; r++)
    begin
      bus_write(tab_addr[r], tab_size[r], tab_data[r]);
      bus_read(tab_addr[r], rd);
      check_value($sformatf("HRDATA@%h", tab_addr[r]), rd, tab_exp[r]);
    end

    // Counting rate, one tick per P+1 cycles
    prescale_p = 3;
    bus_write(ADDR_PRESCALE, HSIZE_WORD, 32'(prescale_p));
    repeat (4) @(posedge HCLK);
    bus_read(ADDR_TIME, t0);
    c0 = cycle_cnt;
    repeat (200) @(posedge HCLK);
    bus_read(ADDR_TIME, t1);
    c1 = cycle_cnt;
    rate  = (c1 - c0) / (prescale_p + 1);
    delta = int'(t1 - t0);
    // Tick count may be off by one at either end
    check_value("time_delta_in_range", 32'(delta >= rate - 1 && delta <= rate + 1), 32'h1);

    // Channel 1 fires a few ticks ahead
    bus_read(ADDR_TIME, t_lo);
    bus_read(ADDR_TIME_MSB, t_hi);
    target = {t_hi, t_lo} + 64'd20;
    bus_write(cmp_addr(1, 1), HSIZE_WORD, target[63:32]);
    bus_write(cmp_addr(1, 0), HSIZE_WORD, target[31:0]);
    bus_write(ADDR_IENABLE, HSIZE_WORD, 32'h2);
    wait_tint(1'b1, WAIT_MAX, "tint never rose for timecmp[1]");
    bus_read(ADDR_IPENDING, rd);
    check_value("pending", rd, 32'h2);
    // Far compare value clears the channel
    bus_write(cmp_addr(1, 1), HSIZE_WORD, t_hi + 32'h100);
    wait_tint(1'b0, 3, "tint stayed high after timecmp[1] rewrite");
    bus_read(ADDR_IPENDING, rd);
    check_value("pending", rd, 32'h0);

    // Channel 2 pends with its enable clear
    bus_read(ADDR_TIME, t_lo);
    bus_read(ADDR_TIME_MSB, t_hi);
    target = {t_hi, t_lo} + 64'd20;
    bus_write(cmp_addr(2, 1), HSIZE_WORD, target[63:32]);
    bus_write(cmp_addr(2, 0), HSIZE_WORD, target[31:0]);
    polls = 0;
    rd    = 32'h0;
    while (rd[2] !== 1'b1)
    begin
      polls++;
      if (polls > POLL_MAX)
        stop_on_timeout("pending bit 2 never set");
      bus_read(ADDR_IPENDING, rd);
    end
    for (int i = 0; i < 20; i++)
    begin
      @(negedge HCLK);
      check_value("tint", 32'(tint), 32'h0);
    end
    bus_read(ADDR_IPENDING, rd);
    check_value("pending", rd, 32'h4);

    if (error_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- build.f
source/timer_pkg.sv
source/timer_bus_port.sv
source/timer_prescaler.sv
source/timer_regs.sv
source/timer_irq.sv
source/timer_top.sv
sim/tb_timer.sv

//--- run.sh
#!/bin/sh
# Build the timer testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_timer -f build.f -o tb_timer \
  && ./obj_dir/tb_timer > sim.log 2>&1 \
  || echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
